/* src/pin_bridge_macros.svh */
`ifndef PIN_BRIDGE_MACROS_SVH
`define PIN_BRIDGE_MACROS_SVH

// word widths on the chip pins

// core to chip word, carried on pin_down_data
`define PB_DOWN_BITS 21

// chip to core word, carried on pin_up_data
`define PB_UP_BITS 34

// entries per direction
// count type in pin_word_pkg is sized from this
`define PB_FIFO_DEPTH 8

`endif

/* src/pin_word_pkg.sv */
`include "pin_bridge_macros.svh"

package pin_word_pkg;

  // one word headed for the chip
  typedef logic [`PB_DOWN_BITS-1:0] down_word_t;

  // one word coming back from the chip
  typedef logic [`PB_UP_BITS-1:0] up_word_t;

  // occupancy needs to reach DEPTH itself, hence the +1
  typedef logic [$clog2(`PB_FIFO_DEPTH+1)-1:0] fifo_count_t;

endpackage

/* src/pin_ctrl_pkg.sv */
package pin_ctrl_pkg;

  // downlink pin transmitter
  typedef enum logic [1:0] {
    wait_word,  // nothing held, looking at the core channel
    valid_low,  // word on the pins, waiting for chip ready
    valid_high  // valid asserted, waiting for ready to fall
  } tx_state_e;

  // uplink pin receiver
  typedef enum logic {
    ready_high, // open for a chip word
    ready_low   // holding a word for the core
  } rx_state_e;

endpackage

/* src/word_fifo.sv */
`timescale 1ns/1ps

module word_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             reset,
  // write side, fed by the producer
  input  logic             in_v,
  input  logic [WIDTH-1:0] in_d,
  output logic             in_a,
  // read side, offered to the consumer
  output logic             out_v,
  output logic [WIDTH-1:0] out_d,
  input  logic             out_a
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0]          mem [DEPTH]; // storage
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  pin_word_pkg::fifo_count_t count;       // words currently held
  logic                      wr_en;
  logic                      rd_en;

  // wrap pointer at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    logic [PTR_W-1:0] n;
    if (p == PTR_W'(DEPTH - 1))
      n = '0;
    else
      n = p + 1'b1;
    return n;
  endfunction

  // in_a high means we are in the ack cycle and v is ignored
  assign wr_en = in_v && !in_a && (count < DEPTH);
  assign rd_en = out_a && out_v; // pop only something that is there

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      in_a   <= 1'b0;
    end else begin
      in_a <= wr_en; // ack follows the latch by one cycle
      if (wr_en)
        wr_ptr <= ptr_next(wr_ptr);
      if (rd_en)
        rd_ptr <= ptr_next(rd_ptr);
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_ptr] <= in_d;
  end

  // head of queue, visible the cycle after the write
  assign out_v = (count != '0);
  assign out_d = out_v ? mem[rd_ptr] : '0; // zero while empty

  // a write into a full fifo would land on the unread head
  no_write_full_a: assert property (
    @(posedge clk) disable iff (reset)
    wr_en && (count != '0) |-> (wr_ptr != rd_ptr)
  ) else $error("word_fifo: write into a full fifo");

  // consumer must not ack an empty fifo
  no_pop_empty_a: assert property (
    @(posedge clk) disable iff (reset)
    out_a |-> out_v
  ) else $error("word_fifo: pop while empty");

  // head word holds until the consumer acks it
  head_stable_a: assert property (
    @(posedge clk) disable iff (reset)
    out_v && !out_a |=> $stable(out_d)
  ) else $error("word_fifo: out_d changed while waiting for ack");

endmodule

/* src/pin_downlink_tx.sv */
`timescale 1ns/1ps

module pin_downlink_tx (
  input  logic                     clk,
  input  logic                     reset,
  // core side, read end of the downlink fifo
  input  logic                     core_v,
  input  pin_word_pkg::down_word_t core_d,
  output logic                     core_a,
  // chip pins
  output logic                     pin_down_valid,
  output pin_word_pkg::down_word_t pin_down_data,
  input  logic                     pin_down_ready
);

  pin_ctrl_pkg::tx_state_e  state;
  pin_ctrl_pkg::tx_state_e  next_state;
  pin_word_pkg::down_word_t next_data;
  logic                     next_a;

  // word, ack and state all come straight from flops
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state         <= pin_ctrl_pkg::wait_word;
      pin_down_data <= '0;
      core_a        <= 1'b0;
    end else begin
      state         <= next_state;
      pin_down_data <= next_data;
      core_a        <= next_a;
    end
  end

  // the chip may sample data at any point while valid is high
  // so data only loads in wait_word or on the edge that ends valid_high
  always_comb begin
    next_state = state;
    next_data  = pin_down_data; // hold by default
    next_a     = 1'b0;
    case (state)
      pin_ctrl_pkg::wait_word: begin
        if (core_v) begin
          next_data  = core_d; // load word, valid stays low one more cycle
          next_a     = 1'b1;
          next_state = pin_ctrl_pkg::valid_low;
        end
      end
      pin_ctrl_pkg::valid_low: begin
        // first cycle here is the ack cycle, core_v ignored
        if (pin_down_ready)
          next_state = pin_ctrl_pkg::valid_high;
      end
      pin_ctrl_pkg::valid_high: begin
        if (!pin_down_ready) begin // chip has taken the word
          if (core_v) begin
            next_data  = core_d; // chain straight into the next word
            next_a     = 1'b1;
            next_state = pin_ctrl_pkg::valid_low;
          end else begin
            next_state = pin_ctrl_pkg::wait_word;
          end
        end
      end
      default: begin
        next_state = pin_ctrl_pkg::wait_word;
      end
    endcase
  end

  // valid is a pure state decode, high only in valid_high
  assign pin_down_valid = (state == pin_ctrl_pkg::valid_high);

  // data frozen for the whole valid window
  data_hold_a: assert property (
    @(posedge clk) disable iff (reset)
    pin_down_valid |=> !pin_down_valid || $stable(pin_down_data)
  ) else $error("pin_downlink_tx: pin_down_data moved under valid");

  // one ack per word taken from the fifo
  ack_pulse_a: assert property (
    @(posedge clk) disable iff (reset)
    core_a |=> !core_a
  ) else $error("pin_downlink_tx: core_a held two cycles");

endmodule

/* src/pin_uplink_rx.sv */
`timescale 1ns/1ps

module pin_uplink_rx (
  input  logic                   clk,
  input  logic                   reset,
  // chip pins
  input  logic                   pin_up_valid,
  input  pin_word_pkg::up_word_t pin_up_data,
  output logic                   pin_up_ready,
  // core side, write end of the uplink fifo
  output logic                   core_v,
  output pin_word_pkg::up_word_t core_d,
  input  logic                   core_a
);

  pin_ctrl_pkg::rx_state_e state;
  pin_ctrl_pkg::rx_state_e next_state;
  pin_word_pkg::up_word_t  next_d;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state  <= pin_ctrl_pkg::ready_high;
      core_d <= '0;
    end else begin
      state  <= next_state;
      core_d <= next_d;
    end
  end

  always_comb begin
    next_state = state;
    next_d     = core_d; // held word
    case (state)
      pin_ctrl_pkg::ready_high: begin
        if (pin_up_valid) begin // chip only drives valid while ready is up
          next_d     = pin_up_data;
          next_state = pin_ctrl_pkg::ready_low;
        end
      end
      pin_ctrl_pkg::ready_low: begin
        if (core_a) // fifo took the word
          next_state = pin_ctrl_pkg::ready_high;
      end
      default: begin
        next_state = pin_ctrl_pkg::ready_high;
      end
    endcase
  end

  // ready and v are always opposite
  assign pin_up_ready = (state == pin_ctrl_pkg::ready_high);
  assign core_v       = (state == pin_ctrl_pkg::ready_low);

  // offered word must not move before the ack
  core_hold_a: assert property (
    @(posedge clk) disable iff (reset)
    core_v |=> !core_v || $stable(core_d)
  ) else $error("pin_uplink_rx: core_d moved while core_v high");

endmodule

/* src/pin_bridge_top.sv */
`timescale 1ns/1ps
`include "pin_bridge_macros.svh"

module pin_bridge_top (
  input  logic                     clk,
  input  logic                     reset,
  // core downlink channel
  input  logic                     down_v,
  input  pin_word_pkg::down_word_t down_d,
  output logic                     down_a,
  // chip downlink pins
  output logic                     pin_down_valid,
  output pin_word_pkg::down_word_t pin_down_data,
  input  logic                     pin_down_ready,
  // chip uplink pins
  input  logic                     pin_up_valid,
  input  pin_word_pkg::up_word_t   pin_up_data,
  output logic                     pin_up_ready,
  // core uplink channel
  output logic                     up_v,
  output pin_word_pkg::up_word_t   up_d,
  input  logic                     up_a
);

  // fifo head to transmitter
  logic                     tx_core_v;
  pin_word_pkg::down_word_t tx_core_d;
  logic                     tx_core_a;

  // receiver to fifo tail
  logic                     rx_core_v;
  pin_word_pkg::up_word_t   rx_core_d;
  logic                     rx_core_a;

  // buffers core words ahead of the slow pin handshake
  word_fifo #(
    .WIDTH (`PB_DOWN_BITS),
    .DEPTH (`PB_FIFO_DEPTH)
  ) down_fifo (
    .clk   (clk),
    .reset (reset),
    .in_v  (down_v),
    .in_d  (down_d),
    .in_a  (down_a),
    .out_v (tx_core_v),
    .out_d (tx_core_d),
    .out_a (tx_core_a)
  );

  pin_downlink_tx u_tx (
    .clk            (clk),
    .reset          (reset),
    .core_v         (tx_core_v),
    .core_d         (tx_core_d),
    .core_a         (tx_core_a),
    .pin_down_valid (pin_down_valid),
    .pin_down_data  (pin_down_data),
    .pin_down_ready (pin_down_ready)
  );

  pin_uplink_rx u_rx (
    .clk          (clk),
    .reset        (reset),
    .pin_up_valid (pin_up_valid),
    .pin_up_data  (pin_up_data),
    .pin_up_ready (pin_up_ready),
    .core_v       (rx_core_v),
    .core_d       (rx_core_d),
    .core_a       (rx_core_a)
  );

  // lets the chip keep sending while the core is slow on up_a
  word_fifo #(
    .WIDTH (`PB_UP_BITS),
    .DEPTH (`PB_FIFO_DEPTH)
  ) up_fifo (
    .clk   (clk),
    .reset (reset),
    .in_v  (rx_core_v),
    .in_d  (rx_core_d),
    .in_a  (rx_core_a),
    .out_v (up_v),
    .out_d (up_d),
    .out_a (up_a)
  );

endmodule

/* dv/pin_bridge_tb.sv */
`timescale 1ns/1ps
`include "pin_bridge_macros.svh"

module pin_bridge_tb;

  localparam int WORDS = 300;              // words per direction
  localparam int LIMIT = WORDS * 40 + 2000; // cycle budget for the whole run
  localparam int CAP   = `PB_FIFO_DEPTH + 1; // fifo plus the word held at the pins
  localparam int DRAIN = 50;               // quiet cycles after the last word

  logic                     clk;
  logic                     reset;
  logic                     down_v;
  pin_word_pkg::down_word_t down_d;
  logic                     down_a;
  logic                     pin_down_valid;
  pin_word_pkg::down_word_t pin_down_data;
  logic                     pin_down_ready;
  logic                     pin_up_valid;
  pin_word_pkg::up_word_t   pin_up_data;
  logic                     pin_up_ready;
  logic                     up_v;
  pin_word_pkg::up_word_t   up_d;
  logic                     up_a;

  pin_word_pkg::down_word_t down_q[$]; // accepted by down_a, not yet off the pins
  pin_word_pkg::up_word_t   up_q[$];   // sent by the chip, not yet taken by the core
  int                       down_taken; // words acked on down_a
  int                       down_done;  // words finished on the pins
  int                       up_sent;
  int                       up_done;
  int                       cycles;
  logic [31:0]              rng;
  int                       ready_hold; // chip stall on pin_down_ready
  int                       send_gap;   // idle cycles before the next chip word
  int                       ack_wait;   // core delay before taking up_d
  logic                     last_valid;
  logic                     last_ready;
  pin_word_pkg::down_word_t last_data;
  logic                     last_up_v;
  logic                     last_up_a;
  pin_word_pkg::up_word_t   last_up_d;

  pin_bridge_top uut (
    .clk            (clk),
    .reset          (reset),
    .down_v         (down_v),
    .down_d         (down_d),
    .down_a         (down_a),
    .pin_down_valid (pin_down_valid),
    .pin_down_data  (pin_down_data),
    .pin_down_ready (pin_down_ready),
    .pin_up_valid   (pin_up_valid),
    .pin_up_data    (pin_up_data),
    .pin_up_ready   (pin_up_ready),
    .up_v           (up_v),
    .up_d           (up_d),
    .up_a           (up_a)
  );

  always #5 clk = ~clk;

  // lcg, upper bits only since the low ones cycle fast
  function automatic logic [15:0] rand16();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng[30:15];
  endfunction

  function automatic logic [47:0] rand48();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    a = rand16();
    b = rand16();
    c = rand16();
    return {a, b, c};
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Testbench failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // core producer on down_v/down_d, new word only after the ack
  task automatic drive_core_down();
    logic [15:0] r;
    logic [47:0] w;
    r = rand16();
    w = rand48();
    if (down_a) begin
      check_value(down_v, 1'b1, "down_a with no word offered");
      down_q.push_back(down_d);
      down_taken++;
      if (down_taken < WORDS && r[1:0] != 2'b00) begin
        down_d <= w[`PB_DOWN_BITS-1:0]; // back to back offer
      end else begin
        down_v <= 1'b0;
      end
    end else if (!down_v && down_taken < WORDS && r[1:0] != 2'b00) begin
      down_v <= 1'b1;
      down_d <= w[`PB_DOWN_BITS-1:0];
    end
  endtask

  // chip side of the downlink pins
  task automatic model_chip_down();
    logic [15:0]              r;
    pin_word_pkg::down_word_t exp;
    r = rand16();
    if (last_valid && pin_down_valid)
      check_value(pin_down_data, last_data, "pin_down_data moved under valid");
    if (!last_valid && pin_down_valid)
      check_value(last_ready, 1'b1, "pin_down_valid rose without ready");
    if (last_valid && !pin_down_valid) begin // valid fell, word complete
      check_value(down_q.size() > 0, 1'b1, "pin word with none expected");
      exp = down_q.pop_front();
      check_value(last_data, exp, "downlink pin word");
      down_done++;
    end
    if (ready_hold > 0) begin
      ready_hold--;
      pin_down_ready <= 1'b0;
    end else if (!pin_down_ready) begin
      pin_down_ready <= (r[1:0] != 2'b00);
    end else if (pin_down_valid && r[2]) begin
      pin_down_ready <= 1'b0; // take the word
      if (r[7:3] == 5'd0)
        ready_hold = 20 + r[13:8]; // long stall, fills down_fifo
    end
    last_valid = pin_down_valid;
    last_ready = pin_down_ready; // what the dut samples at this edge
    last_data  = pin_down_data;
  endtask

  // chip side of the uplink pins
  task automatic model_chip_up();
    logic [15:0] r;
    logic [47:0] w;
    r = rand16();
    w = rand48();
    if (pin_up_valid) begin
      if (!pin_up_ready) begin // receiver latched it
        pin_up_valid <= 1'b0;
        send_gap = r[1:0];
        if (r[7:3] == 5'd0)
          send_gap = 20 + r[13:8];
      end
    end else if (send_gap > 0) begin
      send_gap--;
    end else if (pin_up_ready && up_sent < WORDS) begin
      pin_up_valid <= 1'b1;
      pin_up_data  <= w[`PB_UP_BITS-1:0];
      up_q.push_back(w[`PB_UP_BITS-1:0]);
      up_sent++;
    end
  endtask

  // core consumer on up_v/up_d/up_a
  task automatic drive_core_up();
    logic [15:0]            r;
    pin_word_pkg::up_word_t exp;
    r = rand16();
    if (last_up_v && !last_up_a) begin // no pop at the last edge
      check_value(up_v, 1'b1, "up_v dropped before up_a");
      check_value(up_d, last_up_d, "up_d moved while waiting for up_a");
    end
    last_up_v = up_v;
    last_up_a = up_a;
    last_up_d = up_d;
    if (up_a) begin
      up_a <= 1'b0; // ack cycle, v ignored
    end else if (up_v) begin
      if (ack_wait > 0) begin
        ack_wait--;
      end else begin
        check_value(up_q.size() > 0, 1'b1, "up_v with no chip word sent");
        exp = up_q.pop_front();
        check_value(up_d, exp, "uplink core word");
        up_done++;
        up_a <= 1'b1;
        ack_wait = r[1:0];
        if (r[7:3] == 5'd0)
          ack_wait = 20 + r[13:8]; // withhold up_a, fills up_fifo
      end
    end
  endtask

  always @(posedge clk) begin
    if (!reset) begin
      drive_core_down();
      model_chip_down();
      model_chip_up();
      drive_core_up();
      // more words in flight than the buffers hold means a duplicate
      check_value(down_q.size() <= CAP, 1'b1, "downlink words beyond buffer capacity");
      check_value(up_q.size() <= CAP, 1'b1, "uplink words beyond buffer capacity");
    end
  end

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    down_v         = 1'b0;
    down_d         = '0;
    pin_down_ready = 1'b0;
    pin_up_valid   = 1'b0;
    pin_up_data    = '0;
    up_a           = 1'b0;
    rng            = 32'd28132;
    down_taken     = 0;
    down_done      = 0;
    up_sent        = 0;
    up_done        = 0;
    cycles         = 0;
    ready_hold     = 0;
    send_gap       = 0;
    ack_wait       = 0;
    last_valid     = 1'b0;
    last_ready     = 1'b0;
    last_data      = '0;
    last_up_v      = 1'b0;
    last_up_a      = 1'b0;
    last_up_d      = '0;
    repeat (10) @(posedge clk);
    check_value(down_a, 1'b0, "down_a after reset");
    check_value(up_v, 1'b0, "up_v after reset");
    check_value(pin_down_valid, 1'b0, "pin_down_valid after reset");
    check_value(pin_up_ready, 1'b1, "pin_up_ready after reset");
    check_value(pin_down_data, '0, "pin_down_data after reset");
    check_value(up_d, '0, "up_d after reset");
    reset <= 1'b0;
    while (down_done < WORDS || up_done < WORDS) begin
      @(posedge clk);
      cycles++;
      if (cycles >= LIMIT) begin
        $display("Timeout: only %0d downlink and %0d uplink words done after %0d cycles",
                 down_done, up_done, cycles);
        $display("Testbench failed");
        $fatal(1, "run did not finish in time");
      end
    end
    // quiet stretch, a stray or repeated word still reaches the pin and core checks
    repeat (DRAIN) @(posedge clk);
    @(negedge clk);
    if (down_q.size() == 0 && up_q.size() == 0 && !up_v && !pin_down_valid &&
        pin_up_ready) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Fail at %0t ns: %0d downlink and %0d uplink words left, bridge not idle",
               $time, down_q.size(), up_q.size());
      $display("Testbench failed");
      $fatal(1, "words left in the reference queues");
    end
  end

endmodule

/* flist.f */
+incdir+src
src/pin_word_pkg.sv
src/pin_ctrl_pkg.sv
src/word_fifo.sv
src/pin_downlink_tx.sv
src/pin_uplink_rx.sv
src/pin_bridge_top.sv
dv/pin_bridge_tb.sv
